// ==== all.f ====
logic/patternPkg.sv
logic/patternIfs.sv
logic/asymDualRam.sv
logic/patternRegs.sv
logic/patternSequencer.sv
logic/patternGenTop.sv
verification/patternGenTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module patternGenTb -f all.f \
    && ./obj_dir/VpatternGenTb | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verification/patternGenTb.sv ====
/*
  Testbench for the pattern generator top level.
  Loads the table and the registers over the byte bus, plays patterns
  and compares every valid word with a shadow copy of the table.
  Built and run by the Verilator script next to the file list.
*/
`default_nettype none

module patternGenTb;

    localparam int ClkHalf = 2;
    // Full table fill takes about 2k cycles, the longest play about 1k
    localparam int TimeoutCycles = 20000;
    localparam logic [31:0] Seed = 32'h665d_c4d3;

    logic                clkA = 1'b0;
    logic                rstN;
    patternPkg::busAddrT busAddr;
    patternPkg::byteT    busWrData;
    logic                busWr;
    logic                busRd;
    patternPkg::byteT    busRdData;
    patternPkg::wordT    patternOut;
    logic                patternValid;
    logic                seqBusy;

    patternPkg::byteT shadow [patternPkg::MemBytes];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          playLen = 1;
    int          wordCount = 0;
    bit          burstEnded = 1'b0;
    bit          prevValid = 1'b0;
    logic [31:0] seedValue;

    patternGenTop i_dut (
        .clkA         (clkA),
        .rstN         (rstN),
        .busAddr      (busAddr),
        .busWrData    (busWrData),
        .busWr        (busWr),
        .busRd        (busRd),
        .busRdData    (busRdData),
        .patternOut   (patternOut),
        .patternValid (patternValid),
        .seqBusy      (seqBusy)
    );

    always #ClkHalf clkA = ~clkA;

    // ------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------
    // Byte 0 of a word sits in the low lane
    function automatic patternPkg::wordT expWord(input int index);
        patternPkg::wordT word;
        for (int i = 0; i < patternPkg::WordBytes; i++) begin
            word[8*i +: 8] = shadow[index * patternPkg::WordBytes + i];
        end
        return word;
    endfunction

    function automatic patternPkg::busAddrT tableAddr(input int byteIndex);
        return {1'b1, patternPkg::byteAddrT'(byteIndex)};
    endfunction

    task automatic expectValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic busWrite(input patternPkg::busAddrT addr, input patternPkg::byteT data);
        @(negedge clkA);
        busAddr   = addr;
        busWrData = data;
        busWr     = 1'b1;
        if (addr[10]) begin
            shadow[addr[9:0]] = data;
        end
        @(negedge clkA);
        busWr = 1'b0;
    endtask

    // Read data is due one cycle after the strobe is sampled
    task automatic busReadCheck(input patternPkg::busAddrT addr, input patternPkg::byteT exp);
        @(negedge clkA);
        busAddr = addr;
        busRd   = 1'b1;
        @(negedge clkA);
        busRd = 1'b0;
        expectValue($sformatf("busRdData at 0x%h", addr), 32'(busRdData), 32'(exp));
    endtask

    task automatic fillTable(input int count);
        for (int i = 0; i < count; i++) begin
            busWrite(tableAddr(i), patternPkg::byteT'($urandom));
        end
    endtask

    task automatic startRun(input int len, input int rep);
        int waited;
        busWrite(patternPkg::RegLenLo, patternPkg::byteT'(len));
        busWrite(patternPkg::RegLenHi, patternPkg::byteT'(len >> 8));
        busWrite(patternPkg::RegRepeat, patternPkg::byteT'(rep));
        playLen    = (len == 0) ? patternPkg::MemWords : len;
        wordCount  = 0;
        burstEnded = 1'b0;
        busWrite(patternPkg::RegCtrl, 8'h01);
        waited = 0;
        while (!patternValid && waited < 4) begin
            @(negedge clkA);
            waited++;
        end
        checks++;
        assert (patternValid) else begin
            errors++;
            $display("pattern output did not start within four cycles of the start");
        end
    endtask

    task automatic finishRun(input int rep);
        while (seqBusy) begin
            @(negedge clkA);
        end
        expectValue("valid word count", 32'(wordCount), 32'(playLen * (rep + 1)));
        expectValue("patternValid", 32'(patternValid), 32'h0);
        busReadCheck(patternPkg::RegCtrl, 8'h02);
    endtask

    // ------------------------------------------------------------
    // Output checker and timeout
    // ------------------------------------------------------------
    always @(posedge clkA) begin
        if (rstN) begin
            if (patternValid) begin
                checks++;
                assert (!burstEnded) else begin
                    errors++;
                    $display("patternValid rose again after the burst had ended");
                end
                checks++;
                assert (patternOut === expWord(wordCount % playLen)) else begin
                    errors++;
                    $display("[FAIL] patternOut word %0d = 0x%h, expected 0x%h", wordCount,
                             patternOut, expWord(wordCount % playLen));
                end
                wordCount++;
            end else if (prevValid) begin
                burstEnded = 1'b1;
            end
            prevValid = patternValid;
        end
    end

    always @(posedge clkA) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int addrList [16];
        int len;
        int rep;
        seedValue = $urandom(Seed);
        rstN      = 1'b0;
        busAddr   = '0;
        busWrData = '0;
        busWr     = 1'b0;
        busRd     = 1'b0;
        repeat (4) @(negedge clkA);
        rstN = 1'b1;

        // Reset values
        expectValue("patternValid", 32'(patternValid), 32'h0);
        expectValue("seqBusy", 32'(seqBusy), 32'h0);
        expectValue("busRdData", 32'(busRdData), 32'h0);
        busReadCheck(patternPkg::RegLenLo, 8'h01);
        busReadCheck(patternPkg::RegLenHi, 8'h00);
        busReadCheck(patternPkg::RegRepeat, 8'h00);
        busReadCheck(patternPkg::RegCtrl, 8'h00);

        // Table bytes at random addresses, read back once all are written
        for (int i = 0; i < 16; i++) begin
            addrList[i] = $urandom_range(patternPkg::MemBytes - 1, 0);
            busWrite(tableAddr(addrList[i]), patternPkg::byteT'($urandom));
        end
        for (int i = 0; i < 16; i++) begin
            busReadCheck(tableAddr(addrList[i]), shadow[addrList[i]]);
        end

        // Register readback and an unused address
        busWrite(patternPkg::RegLenLo, 8'h2a);
        busWrite(patternPkg::RegLenHi, 8'h01);
        busWrite(patternPkg::RegRepeat, 8'hc3);
        busReadCheck(patternPkg::RegLenLo, 8'h2a);
        busReadCheck(patternPkg::RegLenHi, 8'h01);
        busReadCheck(patternPkg::RegRepeat, 8'hc3);
        busReadCheck(11'd5, 8'h00);
        busReadCheck(11'h3ff, 8'h00);

        // Five words, three passes
        fillTable(20);
        startRun(5, 2);
        finishRun(2);

        // Start while busy is ignored, done clears on the next start
        startRun(5, 2);
        busWrite(patternPkg::RegCtrl, 8'h01);
        finishRun(2);
        startRun(5, 2);
        busReadCheck(patternPkg::RegCtrl, 8'h01);
        finishRun(2);

        // Random table, length and repeat
        fillTable(patternPkg::MemBytes);
        len = $urandom_range(patternPkg::MemWords, 1);
        rep = $urandom_range(3, 0);
        startRun(len, rep);
        finishRun(rep);

        // Zero length plays the whole table
        startRun(0, 0);
        finishRun(0);

        repeat (2) @(negedge clkA);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/patternGenTop.sv ====
/*
  Top level of the bus-controlled pattern generator.
  Connects the register block, the table memory and the sequencer.
  Load the table and registers over the byte bus, then write bit 0
  of the control register to play the pattern on patternOut.
*/
`default_nettype none

module patternGenTop (
    input  wire                      clkA,
    input  wire                      rstN,
    input  wire patternPkg::busAddrT busAddr,
    input  wire patternPkg::byteT    busWrData,
    input  wire                      busWr,
    input  wire                      busRd,
    output wire patternPkg::byteT    busRdData,
    output wire patternPkg::wordT    patternOut,
    output wire                      patternValid,
    output wire                      seqBusy
);

    memPortIf memPort ();
    seqCtrlIf seqCtrl ();

    patternPkg::wordAddrT wordAddr;
    patternPkg::wordT     wordData;

    assign seqBusy = seqCtrl.busy;

    patternRegs i_regs (
        .clkA      (clkA),
        .rstN      (rstN),
        .busAddr   (busAddr),
        .busWrData (busWrData),
        .busWr     (busWr),
        .busRd     (busRd),
        .busRdData (busRdData),
        .mem       (memPort.host),
        .ctrl      (seqCtrl.regs)
    );

    asymDualRam i_ram (
        .clkA     (clkA),
        .bytePort (memPort.mem),
        .wordAddr (wordAddr),
        .wordData (wordData)
    );

    patternSequencer i_seq (
        .clkA         (clkA),
        .rstN         (rstN),
        .ctrl         (seqCtrl.seq),
        .wordAddr     (wordAddr),
        .wordData     (wordData),
        .patternOut   (patternOut),
        .patternValid (patternValid)
    );

endmodule

`default_nettype wire

// ==== logic/patternSequencer.sv ====
/*
  Pattern playback sequencer.
  On start it walks the table from word 0 to length minus 1, once per
  pass, for repeatCount plus one passes, issuing one wide read per
  clock. The memory latency is covered by a one-stage valid pipeline,
  and the words leave on patternOut as a contiguous valid burst.
*/
`default_nettype none

module patternSequencer (
    input  wire                    clkA,
    input  wire                    rstN,
    seqCtrlIf.seq                  ctrl,
    output patternPkg::wordAddrT   wordAddr,
    input  wire patternPkg::wordT  wordData,
    output patternPkg::wordT       patternOut,
    output logic                   patternValid
);

    patternPkg::seqStateT state;
    patternPkg::lengthT   effLength;
    patternPkg::wordAddrT lastAddr;
    patternPkg::repeatT   passLeft;
    logic                 fetchValid;
    logic                 accept;

    // Zero length plays the whole table
    assign effLength = (ctrl.length == '0) ? patternPkg::lengthT'(patternPkg::MemWords)
                                           : ctrl.length;
    assign accept    = ctrl.start && (state == patternPkg::seqIdle);

    // ------------------------------------------------------------
    // Address walk and pass counting
    // ------------------------------------------------------------
    always_ff @(posedge clkA or negedge rstN) begin
        if (!rstN) begin
            state    <= patternPkg::seqIdle;
            wordAddr <= '0;
            lastAddr <= '0;
            passLeft <= '0;
        end else begin
            case (state)
                patternPkg::seqIdle: begin
                    if (accept) begin
                        state    <= patternPkg::seqRun;
                        wordAddr <= '0;
                        lastAddr <= patternPkg::wordAddrT'(effLength - 1'b1);
                        passLeft <= ctrl.repeatCount;
                    end
                end
                patternPkg::seqRun: begin
                    if (wordAddr == lastAddr) begin
                        wordAddr <= '0;
                        if (passLeft == '0) begin
                            state <= patternPkg::seqIdle;
                        end else begin
                            passLeft <= passLeft - 1'b1;
                        end
                    end else begin
                        wordAddr <= wordAddr + 1'b1;
                    end
                end
                default: state <= patternPkg::seqIdle;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Output pipeline and status
    // ------------------------------------------------------------
    always_ff @(posedge clkA or negedge rstN) begin
        if (!rstN) begin
            fetchValid   <= 1'b0;
            patternValid <= 1'b0;
            patternOut   <= '0;
            ctrl.busy    <= 1'b0;
            ctrl.done    <= 1'b0;
        end else begin
            fetchValid   <= (state == patternPkg::seqRun);
            patternValid <= fetchValid;
            if (fetchValid) begin
                patternOut <= wordData;
            end
            // Last word on the output with nothing behind it ends the run
            if (accept) begin
                ctrl.busy <= 1'b1;
                ctrl.done <= 1'b0;
            end else if (patternValid && !fetchValid) begin
                ctrl.busy <= 1'b0;
                ctrl.done <= 1'b1;
            end
        end
    end

    validBusyA: assert property (
        @(posedge clkA) disable iff (!rstN) patternValid |-> ctrl.busy
    ) else $error("pattern word valid outside a run");

endmodule

`default_nettype wire

// ==== logic/patternRegs.sv ====
/*
  Register bus decoder for the pattern generator.
  Bus bit 10 selects the pattern table, whose accesses pass straight
  to the memory byte port; otherwise the access hits the control,
  length and repeat registers. Read data appears one cycle after the
  read strobe and holds until the next read.
*/
`default_nettype none

module patternRegs (
    input  wire                      clkA,
    input  wire                      rstN,
    input  wire patternPkg::busAddrT busAddr,
    input  wire patternPkg::byteT    busWrData,
    input  wire                      busWr,
    input  wire                      busRd,
    output patternPkg::byteT         busRdData,
    memPortIf.host                   mem,
    seqCtrlIf.regs                   ctrl
);

    logic             tableSel;
    logic             regWr;
    logic             tableRdPend;
    patternPkg::byteT regValue;
    patternPkg::byteT rdHold;

    assign tableSel = busAddr[10];
    assign regWr    = busWr && !tableSel;

    // Table traffic goes directly to the memory
    assign mem.we     = busWr && tableSel;
    assign mem.addr   = busAddr[9:0];
    assign mem.wrData = busWrData;

    // ------------------------------------------------------------
    // Register readback
    // ------------------------------------------------------------
    always_comb begin
        case (busAddr)
            patternPkg::RegCtrl:   regValue = {6'b0, ctrl.done, ctrl.busy};
            patternPkg::RegLenLo:  regValue = ctrl.length[7:0];
            patternPkg::RegLenHi:  regValue = {7'b0, ctrl.length[8]};
            patternPkg::RegRepeat: regValue = ctrl.repeatCount;
            default:               regValue = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Configuration and start
    // ------------------------------------------------------------
    always_ff @(posedge clkA or negedge rstN) begin
        if (!rstN) begin
            ctrl.length      <= patternPkg::lengthT'(1);
            ctrl.repeatCount <= '0;
            ctrl.start       <= 1'b0;
        end else begin
            // Start only from idle, and never twice in a row
            ctrl.start <= regWr && (busAddr == patternPkg::RegCtrl) && busWrData[0]
                          && !ctrl.busy && !ctrl.start;
            if (regWr) begin
                case (busAddr)
                    patternPkg::RegLenLo:  ctrl.length[7:0]  <= busWrData;
                    patternPkg::RegLenHi:  ctrl.length[8]    <= busWrData[0];
                    patternPkg::RegRepeat: ctrl.repeatCount  <= busWrData;
                    default:               ;
                endcase
            end
        end
    end

    // Table reads show the memory byte for one cycle, then the held copy
    always_ff @(posedge clkA or negedge rstN) begin
        if (!rstN) begin
            tableRdPend <= 1'b0;
            rdHold      <= '0;
        end else begin
            tableRdPend <= busRd && tableSel;
            if (busRd && !tableSel) begin
                rdHold <= regValue;
            end else if (tableRdPend) begin
                rdHold <= mem.rdData;
            end
        end
    end

    assign busRdData = tableRdPend ? mem.rdData : rdHold;

    busExclusiveA: assert property (
        @(posedge clkA) disable iff (!rstN) !(busWr && busRd)
    ) else $error("bus write and read strobes high together");

endmodule

`default_nettype wire

// ==== logic/asymDualRam.sv ====
/*
  Pattern table memory with ports of different width.
  The byte port reads and writes single bytes for the register bus.
  The wide port reads four consecutive bytes as one little-endian
  word for the sequencer. Both read outputs are registered, one cycle
  of latency, and a byte read during a write returns the old byte.
*/
`default_nettype none

module asymDualRam (
    input  wire                       clkA,
    memPortIf.mem                     bytePort,
    input  wire patternPkg::wordAddrT wordAddr,
    output patternPkg::wordT          wordData
);

    localparam int LaneBits = $clog2(patternPkg::WordBytes);

    patternPkg::byteT ram [patternPkg::MemBytes];

    // ------------------------------------------------------------
    // Byte port
    // ------------------------------------------------------------
    always_ff @(posedge clkA) begin
        if (bytePort.we) begin
            ram[bytePort.addr] <= bytePort.wrData;
        end
        bytePort.rdData <= ram[bytePort.addr];
    end

    // ------------------------------------------------------------
    // Wide read port
    // ------------------------------------------------------------
    // Byte 0 of the word lands in the low lane
    always_ff @(posedge clkA) begin
        for (int i = 0; i < patternPkg::WordBytes; i++) begin
            wordData[8*i +: 8] <= ram[{wordAddr, LaneBits'(i)}];
        end
    end

    // Write address from the register block must be resolved
    weAddrKnownA: assert property (
        @(posedge clkA) bytePort.we |-> !$isunknown(bytePort.addr)
    ) else $error("byte port write with unknown address %h", bytePort.addr);

endmodule

`default_nettype wire

// ==== logic/patternIfs.sv ====
/*
  Interfaces between the register block and its neighbours.
  memPortIf is the byte-wide table port: the host drives address and
  write data, the memory returns the byte one cycle later.
  seqCtrlIf carries the sequencer configuration and the start pulse
  one way, and the busy and done levels back.
*/
`default_nettype none

interface memPortIf;

    logic                 we;
    patternPkg::byteAddrT addr;
    patternPkg::byteT     wrData;
    patternPkg::byteT     rdData;

    modport host (
        output we,
        output addr,
        output wrData,
        input  rdData
    );

    modport mem (
        input  we,
        input  addr,
        input  wrData,
        output rdData
    );

endinterface

interface seqCtrlIf;

    logic               start;
    patternPkg::lengthT length;
    patternPkg::repeatT repeatCount;
    logic               busy;
    logic               done;

    modport regs (
        output start,
        output length,
        output repeatCount,
        input  busy,
        input  done
    );

    modport seq (
        input  start,
        input  length,
        input  repeatCount,
        output busy,
        output done
    );

endinterface

`default_nettype wire

// ==== logic/patternPkg.sv ====
/*
  Shared definitions for the pattern generator.
  Holds the table geometry, the width types, the register map of the
  byte bus and the sequencer state encoding. Design files refer to
  these by scoped names.
*/
`default_nettype none

package patternPkg;

    // ------------------------------------------------------------
    // Table geometry
    // ------------------------------------------------------------
    localparam int MemBytes  = 1024;
    localparam int WordBytes = 4;
    localparam int MemWords  = MemBytes / WordBytes;

    typedef logic [10:0] busAddrT;   // bit 10 set selects the table
    typedef logic [7:0]  byteT;
    typedef logic [9:0]  byteAddrT;
    typedef logic [31:0] wordT;
    typedef logic [7:0]  wordAddrT;
    typedef logic [8:0]  lengthT;    // words per pass, zero means full table
    typedef logic [7:0]  repeatT;    // extra passes after the first

    // ------------------------------------------------------------
    // Register map, bit 10 clear
    // ------------------------------------------------------------
    localparam busAddrT RegCtrl   = 11'd0;
    localparam busAddrT RegLenLo  = 11'd1;
    localparam busAddrT RegLenHi  = 11'd2;
    localparam busAddrT RegRepeat = 11'd3;

    typedef enum logic {
        seqIdle,
        seqRun
    } seqStateT;

endpackage

`default_nettype wire
